//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_attn_value
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+include
hw/attn_pkg.sv
hw/vector_fifo.sv
hw/axil_regfile.sv
hw/value_accumulator.sv
hw/attn_value_top.sv
test/attn_value_assertions.sv
test/tb_attn_value.sv

//--- hw/attn_pkg.sv
// Types of the value stage whose widths come from attn_macros.svh and whose bus structs carry no IDs
`default_nettype none

`include "attn_macros.svh"

package attn_pkg;

    // One signed V element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // Element 0 sits in the low byte of a bus word
    typedef elem_t [`VEC_LEN-1:0] v_vector_t;

    // Unsigned attention score from the low byte of a bus word
    typedef logic [`SCORE_W-1:0] score_t;

    // One signed accumulator lane
    typedef logic signed [`ACC_W-1:0] acc_t;

    // Accumulated result, one lane per V element
    typedef acc_t [`VEC_LEN-1:0] acc_vector_t;

    // Sequence length or remaining count, 0 to MAX_SEQ_LENGTH
    typedef logic [$clog2(`MAX_SEQ_LENGTH):0] seq_len_t;

    // Master driven AXI4-Lite signals
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]   awaddr;
        logic                      awvalid;
        logic [`AXIL_DATA_W-1:0]   wdata;
        logic [`AXIL_DATA_W/8-1:0] wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [`AXIL_ADDR_W-1:0]   araddr;
        logic                      arvalid;
        logic                      rready;
    } axil_req_t;

    // Slave driven AXI4-Lite signals
    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic                    bvalid;
        logic [1:0]              bresp;
        logic                    arready;
        logic                    rvalid;
        logic [`AXIL_DATA_W-1:0] rdata;
        logic [1:0]              rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- hw/attn_value_top.sv
// Value stage behind one AXI4-Lite slave, with no interrupt so the host polls STATUS
`timescale 1ns/1ns
`default_nettype none

`include "attn_macros.svh"

module attn_value_top
    import attn_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);

    // Register file to V FIFO
    logic      v_push;
    v_vector_t v_push_data;
    logic      v_ready;

    // Register file to score FIFO
    logic   s_push;
    score_t s_push_data;
    logic   s_ready;

    // FIFO heads to the accumulator
    logic      v_valid;
    v_vector_t v_head;
    logic      s_valid;
    score_t    s_head;
    // Shared by both FIFOs
    logic      pop;

    // Run control and result
    logic        start;
    seq_len_t    start_len;
    logic        result_valid;
    acc_vector_t result;

    axil_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .v_push       (v_push),
        .v_push_data  (v_push_data),
        .v_ready      (v_ready),
        .s_push       (s_push),
        .s_push_data  (s_push_data),
        .s_ready      (s_ready),
        .start        (start),
        .start_len    (start_len),
        .result_valid (result_valid),
        .result       (result)
    );

    vector_fifo #(
        .entry_t (v_vector_t),
        .DEPTH   (`MAX_SEQ_LENGTH)
    ) u_v_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (v_push),
        .push_data (v_push_data),
        .pop       (pop),
        .valid     (v_valid),
        .ready     (v_ready),
        .head_data (v_head)
    );

    vector_fifo #(
        .entry_t (score_t),
        .DEPTH   (`MAX_SEQ_LENGTH)
    ) u_s_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (s_push),
        .push_data (s_push_data),
        .pop       (pop),
        .valid     (s_valid),
        .ready     (s_ready),
        .head_data (s_head)
    );

    value_accumulator u_accum (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .start_len    (start_len),
        .v_valid      (v_valid),
        .v_row        (v_head),
        .s_valid      (s_valid),
        .score        (s_head),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- hw/axil_regfile.sv
// AXI4-Lite slave with one outstanding write and one outstanding read, wstrb ignored so every write is full
`timescale 1ns/1ns
`default_nettype none

`include "attn_macros.svh"

module axil_regfile
    import attn_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    output logic        v_push,
    output v_vector_t   v_push_data,
    input  logic        v_ready,
    output logic        s_push,
    output score_t      s_push_data,
    input  logic        s_ready,
    output logic        start,
    output seq_len_t    start_len,
    input  logic        result_valid,
    input  acc_vector_t result
);

    localparam int IDX_W = $clog2(`VEC_LEN);

    // Write channel state
    logic       aw_fire;
    logic       bvalid;
    logic [1:0] bresp;
    logic       wr_seq;
    logic       wr_v;
    logic       wr_s;
    logic       len_ok;
    logic       wr_ok;

    // Read channel state
    logic                    ar_fire;
    logic                    rvalid;
    logic [`AXIL_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic [`AXIL_DATA_W-1:0] rd_data;
    logic                    rd_ok;
    logic [`AXIL_ADDR_W-1:0] res_off;
    logic [IDX_W-1:0]        res_idx;
    logic                    rd_result;

    // AW and W are taken together, and only while no response waits
    assign aw_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;

    // Write address decode
    assign wr_seq = (axil_req.awaddr == `REG_SEQ_LEN);
    assign wr_v   = (axil_req.awaddr == `REG_V_PUSH);
    assign wr_s   = (axil_req.awaddr == `REG_SCORE_PUSH);

    // Legal lengths run from 1 to the FIFO depth
    assign len_ok = (axil_req.wdata != '0) &&
                    (axil_req.wdata <= `AXIL_DATA_W'(`MAX_SEQ_LENGTH));

    // Pushes land on the handshake edge, and a full FIFO drops them
    assign v_push = aw_fire && wr_v && v_ready;
    assign s_push = aw_fire && wr_s && s_ready;
    assign start  = aw_fire && wr_seq && len_ok;

    // Payload slices of the write data
    assign v_push_data = v_vector_t'(axil_req.wdata);
    assign s_push_data = axil_req.wdata[`SCORE_W-1:0];
    assign start_len   = axil_req.wdata[$bits(seq_len_t)-1:0];

    // Anything that took effect is OKAY, the rest is SLVERR
    assign wr_ok = v_push || s_push || start;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (aw_fire) begin
            bvalid <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            bresp <= wr_ok ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
        end
    end

    // One read in flight, AR taken while R is idle
    assign ar_fire = axil_req.arvalid && !rvalid;

    // Result words occupy VEC_LEN aligned slots from REG_RESULT0
    assign res_off   = axil_req.araddr - `REG_RESULT0;
    assign res_idx   = res_off[IDX_W+1:2];
    assign rd_result = (axil_req.araddr >= `REG_RESULT0) &&
                       (res_off < `AXIL_ADDR_W'(4 * `VEC_LEN)) &&
                       (res_off[1:0] == 2'b00);

    always_comb begin
        rd_data = '0;
        rd_ok   = 1'b0;
        if (axil_req.araddr == `REG_STATUS) begin
            // Bit 0 done, bit 1 V FIFO full, bit 2 score FIFO full
            rd_data = {{(`AXIL_DATA_W-3){1'b0}}, !s_ready, !v_ready, result_valid};
            rd_ok   = 1'b1;
        end else if (rd_result) begin
            // Sign extend the lane to the bus width
            rd_data = {{(`AXIL_DATA_W-`ACC_W){result[res_idx][`ACC_W-1]}},
                       result[res_idx]};
            rd_ok   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    // Unmapped reads return zero with SLVERR
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_data;
            rresp <= rd_ok ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
        end
    end

    // Response bundle
    always_comb begin
        axil_rsp.awready = aw_fire;
        axil_rsp.wready  = aw_fire;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = ar_fire;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

endmodule

`default_nettype wire

//--- hw/value_accumulator.sv
// Pairs score and V row strictly by FIFO order, and the sum is neither scaled nor rounded
`timescale 1ns/1ns
`default_nettype none

`include "attn_macros.svh"

module value_accumulator
    import attn_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  seq_len_t    start_len,
    input  logic        v_valid,
    input  v_vector_t   v_row,
    input  logic        s_valid,
    input  score_t      score,
    output logic        pop,
    output logic        result_valid,
    output acc_vector_t result
);

    // Pairs still owed to the current run
    seq_len_t remaining;

    // Running weighted sum, one lane per element
    acc_vector_t acc;

    // Unsigned score times signed element, widened to an accumulator lane
    function automatic acc_t weigh(input elem_t elem, input score_t s);
        logic signed [`SCORE_W:0]         s_ext;
        logic signed [`SCORE_W+`ELEM_W:0] prod;
        // Zero bit on top keeps the score positive in signed math
        s_ext = $signed({1'b0, s});
        prod  = s_ext * elem;
        return acc_t'(prod);
    endfunction

    // Take one pair per cycle while a run is open
    // A start in the same cycle wins, so no pair is lost to the clear
    assign pop = (remaining != '0) && v_valid && s_valid && !start;

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining    <= '0;
            result_valid <= 1'b0;
        end else if (start) begin
            remaining    <= start_len;
            result_valid <= 1'b0;
        end else if (pop) begin
            remaining <= remaining - 1'b1;
            // Last pair of the run
            if (remaining == seq_len_t'(1)) begin
                result_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (pop) begin
            for (int i = 0; i < `VEC_LEN; i++) begin
                acc[i] <= acc[i] + weigh(v_row[i], score);
            end
        end
    end

    // Lanes are read live, and result_valid says when they are final
    assign result = acc;

endmodule

`default_nettype wire

//--- hw/vector_fifo.sv
// DEPTH must be a power of two and callers test ready before push and valid before pop
`timescale 1ns/1ns
`default_nettype none

`include "attn_macros.svh"

module vector_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = `MAX_SEQ_LENGTH
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output logic   valid,
    output logic   ready,
    output entry_t head_data
);

    localparam int PTR_W = $clog2(DEPTH);

    // Storage, written at tail and read at head
    entry_t mem [DEPTH];

    // Pointers carry one extra wrap bit above the index
    logic [PTR_W:0] head;
    logic [PTR_W:0] tail;

    // Empty when pointers match exactly
    assign valid = (head != tail);

    // Full when only the wrap bits differ
    assign ready = ((head ^ tail) != {1'b1, {PTR_W{1'b0}}});

    // Oldest entry shown without a clock
    assign head_data = mem[head[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail[PTR_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- include/attn_macros.svh
// Sizes and register map of the value stage, where MAX_SEQ_LENGTH must stay a power of two
`ifndef ATTN_MACROS_SVH
`define ATTN_MACROS_SVH

// Vector shape and element widths
`define VEC_LEN         4
`define ELEM_W          8
`define SCORE_W         8
// 16 x 255 x 128 fits without overflow
`define ACC_W           24

// FIFO depth and longest legal run
`define MAX_SEQ_LENGTH  16

// AXI4-Lite bus widths
`define AXIL_ADDR_W     8
`define AXIL_DATA_W     32

// Register offsets, result words follow REG_RESULT0 at a 4 byte stride
`define REG_SEQ_LEN     8'h00
`define REG_V_PUSH      8'h04
`define REG_SCORE_PUSH  8'h08
`define REG_STATUS      8'h0C
`define REG_RESULT0     8'h10

// Response codes
`define AXIL_RESP_OKAY   2'b00
`define AXIL_RESP_SLVERR 2'b10

`endif

//--- test/attn_trace.txt
# Columns in hex: W addr data bresp | R addr rdata rresp | P addr mask masked_value
# Registers: 00 length, 04 V push, 08 score push, 0C status, 10..1C result words
R 0C 00000000 0
R 20 00000000 2
R 04 00000000 2
R 12 00000000 2
W 40 12345678 2
W 0C 00000001 2
W 00 00000000 2
W 00 00000011 2
P 0C 00000001 00000000
W 00 00000003 0
W 04 7F80FF01 0
W 04 10F005FE 0
W 04 00030201 0
W 08 000000FF 0
W 08 00000010 0
W 08 00000003 0
P 0C 00000001 00000001
R 10 000000E2 0
R 14 FFFFFF57 0
R 18 FFFF7F89 0
R 1C 00007F81 0
W 08 00000002 0
W 08 00000080 0
W 04 01020304 0
W 04 FF7F8081 0
R 0C 00000001 0
W 00 00000002 0
P 0C 00000001 00000001
R 10 FFFFC088 0
R 14 FFFFC006 0
R 18 00003F84 0
R 1C FFFFFF82 0
W 00 00000001 0
R 0C 00000000 0
R 10 00000000 0
W 04 00000005 0
W 08 00000003 0
P 0C 00000001 00000001
R 10 0000000F 0
R 14 00000000 0
W 04 0100FF01 0
W 04 0100FE02 0
W 04 0100FD03 0
W 04 0100FC04 0
W 04 0100FB05 0
W 04 0100FA06 0
W 04 0100F907 0
W 04 0100F808 0
W 04 0100F709 0
W 04 0100F60A 0
W 04 0100F50B 0
W 04 0100F40C 0
W 04 0100F30D 0
W 04 0100F20E 0
W 04 0100F10F 0
W 04 0100F010 0
R 0C 00000003 0
W 04 7F7F7F7F 2
W 00 00000010 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
W 08 00000002 0
P 0C 00000001 00000001
R 10 00000110 0
R 14 FFFFFEF0 0
R 18 00000000 0
R 1C 00000020 0
R 0C 00000001 0

//--- test/attn_value_assertions.sv
// Bound into attn_value_top and checks FIFO push/pop rules and AXI4-Lite response hold, reset cycles skipped
`timescale 1ns/1ns
`default_nettype none

module attn_value_assertions
    import attn_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      v_push,
    input logic      v_ready,
    input logic      s_push,
    input logic      s_ready,
    input logic      pop,
    input logic      v_valid,
    input logic      s_valid,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp
);

    // Failed assertion count
    int violations = 0;

    // No push into a full FIFO
    a_v_push: assert property (@(posedge clk) disable iff (rst) v_push |-> v_ready)
        else begin
            violations++;
            $error("V FIFO pushed while full");
        end

    a_s_push: assert property (@(posedge clk) disable iff (rst) s_push |-> s_ready)
        else begin
            violations++;
            $error("Score FIFO pushed while full");
        end

    // Shared pop needs both heads present
    a_pop: assert property (@(posedge clk) disable iff (rst) pop |-> (v_valid && s_valid))
        else begin
            violations++;
            $error("FIFO popped while empty");
        end

    // B response stays up with a stable code until BREADY
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (axil_rsp.bvalid && !axil_req.bready) |=> (axil_rsp.bvalid && $stable(axil_rsp.bresp)))
        else begin
            violations++;
            $error("BVALID or BRESP changed before BREADY");
        end

    // R response stays up with stable data until RREADY
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        (axil_rsp.rvalid && !axil_req.rready) |=> (axil_rsp.rvalid && $stable(axil_rsp.rdata)))
        else begin
            violations++;
            $error("RVALID or RDATA changed before RREADY");
        end

endmodule

bind attn_value_top attn_value_assertions u_assert (
    .clk      (clk),
    .rst      (rst),
    .v_push   (v_push),
    .v_ready  (v_ready),
    .s_push   (s_push),
    .s_ready  (s_ready),
    .pop      (pop),
    .v_valid  (v_valid),
    .s_valid  (s_valid),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
);

`default_nettype wire

//--- test/tb_attn_value.sv
// Replays test/attn_trace.txt, so it must run from the project root, with one transaction in flight
`timescale 1ns/1ns
`default_nettype none

`include "attn_macros.svh"

module tb_attn_value
    import attn_pkg::*;
();

    localparam int CLK_HALF   = 20;
    localparam int HS_TIMEOUT = 20;
    localparam int POLL_LIMIT = 50;

    logic      clk;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    // Random delay state
    logic [31:0] rng_state;

    // Handshakes seen by the master on each request channel
    int aw_count;
    int w_count;
    int ar_count;

    attn_value_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #CLK_HALF clk = ~clk;

    // Counted on the rising edge where the DUT samples them
    always @(posedge clk) begin
        if (axil_req.awvalid && axil_rsp.awready) begin
            aw_count <= aw_count + 1;
        end
        if (axil_req.wvalid && axil_rsp.wready) begin
            w_count <= w_count + 1;
        end
        if (axil_req.arvalid && axil_rsp.arready) begin
            ar_count <= ar_count + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Zero to three idle cycles that end on a falling edge
    task automatic idle_random();
        int n;
        rng_state = xorshift32(rng_state);
        n = int'(rng_state % 32'd4);
        repeat (n) @(negedge clk);
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s response %0d, expected %0d",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_data(input logic [`AXIL_DATA_W-1:0] got,
                              input logic [`AXIL_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s data 0x%08h, expected 0x%08h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s handshakes %0d, expected %0d",
                                    $time, what, got, exp));
        end
    endtask

    // Steps one falling edge at a time until BVALID or RVALID reaches a level
    task automatic wait_flag(input bit is_write, input bit level, input string what);
        int cycles;
        cycles = 0;
        while ((is_write ? axil_rsp.bvalid : axil_rsp.rvalid) !== level) begin
            if (cycles == HS_TIMEOUT) begin
                stop_on_error($sformatf("Timeout at %0t ns: %s", $time, what));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int aw_start;
        int w_start;
        idle_random();
        aw_start = aw_count;
        w_start  = w_count;
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        axil_req.wvalid  = 1'b1;
        // BVALID rises on the edge that takes AW and W
        wait_flag(1'b1, 1'b1, "write channel hung, no BVALID after AW and W");
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        // AWREADY and WREADY each pulse once for the request
        check_count(aw_count - aw_start, 1, "write address");
        check_count(w_count - w_start, 1, "write data");
        resp = axil_rsp.bresp;
        idle_random();
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
        wait_flag(1'b1, 1'b0, "write channel hung, BVALID stayed high after BREADY");
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int ar_start;
        idle_random();
        ar_start = ar_count;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        wait_flag(1'b0, 1'b1, "read channel hung, no RVALID after AR");
        axil_req.arvalid = 1'b0;
        check_count(ar_count - ar_start, 1, "read address");
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        idle_random();
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
        wait_flag(1'b0, 1'b0, "read channel hung, RVALID stayed high after RREADY");
    endtask

    // Reads until the masked word matches
    task automatic poll_reg(input logic [7:0] addr, input logic [31:0] mask,
                            input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        int          tries;
        tries = 0;
        axil_read(addr, data, resp);
        check_resp(resp, `AXIL_RESP_OKAY, "poll read");
        while ((data & mask) !== exp) begin
            if (tries == POLL_LIMIT) begin
                stop_on_error($sformatf("Timeout at %0t ns: register 0x%02h never matched 0x%08h",
                                        $time, addr, exp));
            end else begin
                axil_read(addr, data, resp);
                check_resp(resp, `AXIL_RESP_OKAY, "poll read");
                tries++;
            end
        end
    endtask

    task automatic run_trace(input int fd, output int count);
        string       line;
        int          n;
        int          line_no;
        logic [7:0]  cmd;
        logic [31:0] addr;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        logic [31:0] rdata;
        logic [1:0]  resp;
        string       what;
        line_no = 0;
        count   = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // Skip blank and comment lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h %h", cmd, addr, arg_b, arg_c);
                what = $sformatf("line %0d addr 0x%02h", line_no, addr[7:0]);
                count++;
                if (n != 4) begin
                    stop_on_error($sformatf("Trace line %0d could not be parsed", line_no));
                end else begin
                    case (cmd)
                        "W": begin
                            axil_write(addr[7:0], arg_b, resp);
                            check_resp(resp, arg_c[1:0], {"write ", what});
                        end
                        "R": begin
                            axil_read(addr[7:0], rdata, resp);
                            check_resp(resp, arg_c[1:0], {"read ", what});
                            check_data(rdata, arg_b, {"read ", what});
                        end
                        "P": poll_reg(addr[7:0], arg_b, arg_c);
                        default: stop_on_error($sformatf("Trace line %0d has unknown command",
                                                         line_no));
                    endcase
                end
            end
        end
    endtask

    initial begin
        int fd;
        int count;
        clk       = 1'b0;
        rst       = 1'b1;
        axil_req  = '0;
        rng_state = 32'd84;
        aw_count  = 0;
        w_count   = 0;
        ar_count  = 0;
        fd = $fopen("test/attn_trace.txt", "r");
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (fd == 0) begin
            stop_on_error("Could not open the trace file test/attn_trace.txt");
        end else begin
            run_trace(fd, count);
            $fclose(fd);
            if (i_dut.u_assert.violations != 0) begin
                stop_on_error("Bound assertions failed during the run");
            end else if (count == 0) begin
                stop_on_error("The trace file held no commands");
            end else begin
                $display("Done: no errors");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire
